// ==== build.sh ====
#!/bin/sh
# Compile and run the read crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module axicb_tb -Mdir obj_dir -o axicb_sim -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running after a failed assertion so the summary line is printed
./obj_dir/axicb_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -q "Test FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== rtl/axicb_bus_pkg.sv ====
////////////////////
// AXI4-lite read channel payloads, single beat only.
////////////////////

package axicb_bus_pkg;

    // AXI response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    ////////////////////
    // Read address channel
    ////////////////////

    typedef struct packed {
        logic [axicb_map_pkg::ID_W-1:0]   id;
        logic [axicb_map_pkg::ADDR_W-1:0] addr;
    } ar_t;

    ////////////////////
    // Read data channel
    ////////////////////

    // No last flag, every read is one beat
    typedef struct packed {
        logic [axicb_map_pkg::ID_W-1:0]   id;
        logic [axicb_map_pkg::DATA_W-1:0] data;
        resp_e                            resp;
    } r_t;

endpackage

// ==== rtl/axicb_map_pkg.sv ====
////////////////////
// Two masters and two slaves with a fixed address map.
// The master index sits in the top ID bits and is replaced by the crossbar.
////////////////////

package axicb_map_pkg;

    // Port counts
    localparam int MST_NB = 2;
    localparam int SLV_NB = 2;

    // Index widths derived from the port counts
    localparam int MST_IDX_W = $clog2(MST_NB);
    localparam int SLV_IDX_W = $clog2(SLV_NB);

    ////////////////////
    // Channel widths
    ////////////////////

    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;

    // The most significant MST_IDX_W bits carry the master index
    localparam int ID_W = 4;

    ////////////////////
    // Address map
    ////////////////////

    // Slave 0, first 4 KB
    localparam logic [ADDR_W-1:0] SLV0_BASE = 16'h0000;
    localparam logic [ADDR_W-1:0] SLV0_LAST = 16'h0FFF;

    // Slave 1, second 4 KB
    localparam logic [ADDR_W-1:0] SLV1_BASE = 16'h1000;
    localparam logic [ADDR_W-1:0] SLV1_LAST = 16'h1FFF;

    // Anything above SLV1_LAST gets a DECERR from the master port

endpackage

// ==== rtl/axicb_mst_port.sv ====
////////////////////
// One pending DECERR at most, it blocks new addresses until returned.
////////////////////

`timescale 1ns/10ps

module axicb_mst_port #(
    parameter logic [axicb_map_pkg::MST_IDX_W-1:0] PORT_INDEX = '0
) (
    input  logic                              aclk,
    input  logic                              i_reset,
    // Master side
    input  axicb_bus_pkg::ar_t                i_ar,
    input  logic                              i_arvalid,
    output logic                              o_arready,
    output axicb_bus_pkg::r_t                 o_r,
    output logic                              o_rvalid,
    input  logic                              i_rready,
    // Arbiter side
    output logic [axicb_map_pkg::SLV_NB-1:0]  o_req,
    input  logic [axicb_map_pkg::SLV_NB-1:0]  i_grant,
    output axicb_bus_pkg::ar_t                o_ar,
    // Slave responses, shared by all ports
    input  axicb_bus_pkg::r_t                 i_slv_r [axicb_map_pkg::SLV_NB],
    input  logic [axicb_map_pkg::SLV_NB-1:0]  i_slv_rvalid,
    output logic [axicb_map_pkg::SLV_NB-1:0]  o_slv_rready
);

    localparam int ID_W  = axicb_map_pkg::ID_W;
    localparam int IDX_W = axicb_map_pkg::MST_IDX_W;

    logic [axicb_map_pkg::SLV_NB-1:0]    hit;
    logic                                mapped;
    logic                                dec_pending;
    logic [ID_W-1:0]                     dec_id;
    axicb_bus_pkg::r_t                   dec_r;
    logic                                pick_found;
    logic [axicb_map_pkg::SLV_IDX_W-1:0] pick_idx;
    logic                                resp_hold;
    logic                                hold_found;
    logic [axicb_map_pkg::SLV_IDX_W-1:0] hold_idx;
    logic                                sel_found;
    logic [axicb_map_pkg::SLV_IDX_W-1:0] sel_idx;

    function automatic logic in_range(
        input logic [axicb_map_pkg::ADDR_W-1:0] addr,
        input logic [axicb_map_pkg::ADDR_W-1:0] base,
        input logic [axicb_map_pkg::ADDR_W-1:0] last
    );
        return (addr >= base) && (addr <= last);
    endfunction

    ////////////////////
    // Address path
    ////////////////////

    assign hit[0] = in_range(i_ar.addr, axicb_map_pkg::SLV0_BASE, axicb_map_pkg::SLV0_LAST);
    assign hit[1] = in_range(i_ar.addr, axicb_map_pkg::SLV1_BASE, axicb_map_pkg::SLV1_LAST);
    assign mapped = |hit;

    assign o_req = hit & {axicb_map_pkg::SLV_NB{i_arvalid & ~dec_pending}};

    // Top ID bits carry the port index toward the slave
    always_comb begin
        o_ar = i_ar;
        o_ar.id[ID_W-1 -: IDX_W] = PORT_INDEX;
    end

    // Granted already includes the slice ready
    assign o_arready = ~dec_pending & (mapped ? |(i_grant & hit) : 1'b1);

    // Local DECERR for unmapped reads
    always_ff @(posedge aclk) begin
        if (i_reset) begin
            dec_pending <= 1'b0;
        end else if (i_arvalid && o_arready && !mapped) begin
            dec_pending <= 1'b1;
        end else if (dec_pending && !sel_found && i_rready) begin
            dec_pending <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_arvalid && o_arready && !mapped) begin
            dec_id <= i_ar.id;
        end
    end

    assign dec_r.id   = dec_id;
    assign dec_r.data = '0;
    assign dec_r.resp = axicb_bus_pkg::RESP_DECERR;

    ////////////////////
    // Response path
    ////////////////////

    // Slave 0 first, DECERR last
    always_comb begin
        pick_found = 1'b0;
        pick_idx   = '0;
        for (int s = 0; s < axicb_map_pkg::SLV_NB; s++) begin
            if (!pick_found && i_slv_rvalid[s] &&
                i_slv_r[s].id[ID_W-1 -: IDX_W] == PORT_INDEX) begin
                pick_found = 1'b1;
                pick_idx   = axicb_map_pkg::SLV_IDX_W'(s);
            end
        end
    end

    // A stalled response stays selected until the master takes it
    assign sel_found = resp_hold ? hold_found : pick_found;
    assign sel_idx   = resp_hold ? hold_idx : pick_idx;

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            resp_hold <= 1'b0;
        end else begin
            resp_hold <= o_rvalid & ~i_rready;
        end
    end

    always_ff @(posedge aclk) begin
        hold_found <= sel_found;
        hold_idx   <= sel_idx;
    end

    assign o_rvalid = sel_found | dec_pending;
    assign o_r      = sel_found ? i_slv_r[sel_idx] : dec_r;

    always_comb begin
        o_slv_rready = '0;
        if (sel_found) begin
            o_slv_rready[sel_idx] = i_rready;
        end
    end

endmodule

// ==== rtl/axicb_read_xbar.sv ====
////////////////////
// Read-only crossbar, one slice per slave channel.
////////////////////

`timescale 1ns/10ps

module axicb_read_xbar (
    input  logic                              aclk,
    input  logic                              i_reset,
    // Master interfaces
    input  axicb_bus_pkg::ar_t                i_m_ar      [axicb_map_pkg::MST_NB],
    input  logic [axicb_map_pkg::MST_NB-1:0]  i_m_arvalid,
    output logic [axicb_map_pkg::MST_NB-1:0]  o_m_arready,
    output axicb_bus_pkg::r_t                 o_m_r       [axicb_map_pkg::MST_NB],
    output logic [axicb_map_pkg::MST_NB-1:0]  o_m_rvalid,
    input  logic [axicb_map_pkg::MST_NB-1:0]  i_m_rready,
    // Slave interfaces
    output axicb_bus_pkg::ar_t                o_s_ar      [axicb_map_pkg::SLV_NB],
    output logic [axicb_map_pkg::SLV_NB-1:0]  o_s_arvalid,
    input  logic [axicb_map_pkg::SLV_NB-1:0]  i_s_arready,
    input  axicb_bus_pkg::r_t                 i_s_r       [axicb_map_pkg::SLV_NB],
    input  logic [axicb_map_pkg::SLV_NB-1:0]  i_s_rvalid,
    output logic [axicb_map_pkg::SLV_NB-1:0]  o_s_rready
);

    localparam int MST_NB = axicb_map_pkg::MST_NB;
    localparam int SLV_NB = axicb_map_pkg::SLV_NB;

    // Port view, indexed by master then slave
    logic [SLV_NB-1:0]  port_req    [MST_NB];
    logic [SLV_NB-1:0]  port_grant  [MST_NB];
    logic [SLV_NB-1:0]  port_rready [MST_NB];
    axicb_bus_pkg::ar_t port_ar     [MST_NB];

    // Slave view, indexed by slave then master
    logic [MST_NB-1:0]  arb_req     [SLV_NB];
    logic [MST_NB-1:0]  arb_grant   [SLV_NB];
    logic [MST_NB-1:0]  rready_t    [SLV_NB];
    axicb_bus_pkg::ar_t arb_ar      [SLV_NB];
    logic [SLV_NB-1:0]  arb_valid;
    logic [SLV_NB-1:0]  ar_ready;
    axicb_bus_pkg::r_t  slv_r       [SLV_NB];
    logic [SLV_NB-1:0]  slv_rvalid;
    logic [SLV_NB-1:0]  slv_rready;

    ////////////////////
    // Master ports
    ////////////////////

    for (genvar m = 0; m < MST_NB; m++) begin : MST_PORT_GEN
        axicb_mst_port #(
            .PORT_INDEX (axicb_map_pkg::MST_IDX_W'(m))
        ) mst_port (
            .aclk         (aclk),
            .i_reset      (i_reset),
            .i_ar         (i_m_ar[m]),
            .i_arvalid    (i_m_arvalid[m]),
            .o_arready    (o_m_arready[m]),
            .o_r          (o_m_r[m]),
            .o_rvalid     (o_m_rvalid[m]),
            .i_rready     (i_m_rready[m]),
            .o_req        (port_req[m]),
            .i_grant      (port_grant[m]),
            .o_ar         (port_ar[m]),
            .i_slv_r      (slv_r),
            .i_slv_rvalid (slv_rvalid),
            .o_slv_rready (port_rready[m])
        );
    end

    ////////////////////
    // Transpose between ports and slaves
    ////////////////////

    for (genvar s = 0; s < SLV_NB; s++) begin : TRANSPOSE_S_GEN
        for (genvar m = 0; m < MST_NB; m++) begin : TRANSPOSE_M_GEN
            assign arb_req[s][m]    = port_req[m][s];
            // Only the winner sees the slice ready
            assign port_grant[m][s] = arb_grant[s][m] & ar_ready[s];
            assign rready_t[s][m]   = port_rready[m][s];
        end
        assign slv_rready[s] = |rready_t[s];
    end

    ////////////////////
    // Arbiters and slave-side slices
    ////////////////////

    for (genvar s = 0; s < SLV_NB; s++) begin : SLV_SIDE_GEN
        axicb_slv_arbiter slv_arb (
            .aclk    (aclk),
            .i_reset (i_reset),
            .i_req   (arb_req[s]),
            .i_ar    (port_ar),
            .o_grant (arb_grant[s]),
            .o_ar    (arb_ar[s]),
            .o_valid (arb_valid[s]),
            .i_ready (ar_ready[s])
        );

        axicb_reg_slice #(
            .payload_t (axicb_bus_pkg::ar_t)
        ) ar_slice (
            .aclk    (aclk),
            .i_reset (i_reset),
            .i_valid (arb_valid[s]),
            .o_ready (ar_ready[s]),
            .i_data  (arb_ar[s]),
            .o_valid (o_s_arvalid[s]),
            .i_ready (i_s_arready[s]),
            .o_data  (o_s_ar[s])
        );

        axicb_reg_slice #(
            .payload_t (axicb_bus_pkg::r_t)
        ) r_slice (
            .aclk    (aclk),
            .i_reset (i_reset),
            .i_valid (i_s_rvalid[s]),
            .o_ready (o_s_rready[s]),
            .i_data  (i_s_r[s]),
            .o_valid (slv_rvalid[s]),
            .i_ready (slv_rready[s]),
            .o_data  (slv_r[s])
        );
    end

endmodule

// ==== rtl/axicb_reg_slice.sv ====
////////////////////
// Two-entry slice, all outputs registered.
////////////////////

`timescale 1ns/10ps

module axicb_reg_slice #(
    parameter type payload_t = logic
) (
    input  logic     aclk,
    input  logic     i_reset,
    // Sender side
    input  logic     i_valid,
    output logic     o_ready,
    input  payload_t i_data,
    // Receiver side
    output logic     o_valid,
    input  logic     i_ready,
    output payload_t o_data
);

    logic     skid_valid;
    payload_t skid_data;
    logic     main_load;

    // Main register can take new data when empty or draining
    assign main_load = ~o_valid | i_ready;

    // Only a full skid entry stops the sender
    assign o_ready = ~skid_valid;

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            o_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else if (main_load) begin
            // Skid entry drains first to keep order
            o_valid    <= skid_valid | i_valid;
            skid_valid <= 1'b0;
        end else if (i_valid && o_ready) begin
            skid_valid <= 1'b1;
        end
    end

    // Payload path
    always_ff @(posedge aclk) begin
        if (main_load) begin
            if (skid_valid) begin
                o_data <= skid_data;
            end else if (i_valid) begin
                o_data <= i_data;
            end
        end else if (i_valid && o_ready) begin
            skid_data <= i_data;
        end
    end

endmodule

// ==== rtl/axicb_slv_arbiter.sv ====
////////////////////
// Round-robin over the masters, grant locked until the transfer completes.
////////////////////

`timescale 1ns/10ps

module axicb_slv_arbiter (
    input  logic                              aclk,
    input  logic                              i_reset,
    input  logic [axicb_map_pkg::MST_NB-1:0]  i_req,
    input  axicb_bus_pkg::ar_t                i_ar [axicb_map_pkg::MST_NB],
    output logic [axicb_map_pkg::MST_NB-1:0]  o_grant,
    output axicb_bus_pkg::ar_t                o_ar,
    output logic                              o_valid,
    input  logic                              i_ready
);

    typedef enum logic {
        ARB_IDLE,
        ARB_HOLD
    } arb_state_e;

    arb_state_e                           state;
    logic [axicb_map_pkg::MST_IDX_W-1:0]  rr_ptr;
    logic [axicb_map_pkg::MST_IDX_W-1:0]  rr_idx;
    logic                                 rr_found;
    logic [axicb_map_pkg::MST_IDX_W-1:0]  hold_idx;
    logic [axicb_map_pkg::MST_IDX_W-1:0]  grant_idx;
    logic [axicb_map_pkg::MST_IDX_W-1:0]  next_ptr;

    ////////////////////
    // Request selection
    ////////////////////

    // First requester at or after the pointer
    always_comb begin
        int unsigned cand;
        rr_found = 1'b0;
        rr_idx   = '0;
        for (int k = 0; k < axicb_map_pkg::MST_NB; k++) begin
            cand = (int'(rr_ptr) + k) % axicb_map_pkg::MST_NB;
            if (!rr_found && i_req[cand]) begin
                rr_found = 1'b1;
                rr_idx   = axicb_map_pkg::MST_IDX_W'(cand);
            end
        end
    end

    assign grant_idx = (state == ARB_HOLD) ? hold_idx : rr_idx;
    assign o_valid   = (state == ARB_HOLD) | rr_found;
    assign o_ar      = i_ar[grant_idx];

    always_comb begin
        o_grant = '0;
        if (o_valid) begin
            o_grant[grant_idx] = 1'b1;
        end
    end

    // Next in line after the winner
    assign next_ptr = (int'(grant_idx) == axicb_map_pkg::MST_NB - 1) ?
                      '0 : grant_idx + 1'b1;

    ////////////////////
    // Grant lock FSM
    ////////////////////

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            state    <= ARB_IDLE;
            rr_ptr   <= '0;
            hold_idx <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (rr_found) begin
                        if (i_ready) begin
                            rr_ptr <= next_ptr;
                        end else begin
                            // Slice is full, keep this winner
                            state    <= ARB_HOLD;
                            hold_idx <= rr_idx;
                        end
                    end
                end
                ARB_HOLD: begin
                    if (i_ready) begin
                        state  <= ARB_IDLE;
                        rr_ptr <= next_ptr;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

// ==== src.f ====
rtl/axicb_map_pkg.sv
rtl/axicb_bus_pkg.sv
rtl/axicb_reg_slice.sv
rtl/axicb_slv_arbiter.sv
rtl/axicb_mst_port.sv
rtl/axicb_read_xbar.sv
tests/axicb_properties.sv
tests/axicb_tb.sv

// ==== tests/axicb_properties.sv ====
////////////////////
// Bound into the crossbar top, also watches its arbiter and slice signals.
// err_cnt holds the number of failed checks.
////////////////////

`timescale 1ns/10ps

module axicb_properties (
    input logic                              aclk,
    input logic                              i_reset,
    input axicb_bus_pkg::ar_t                i_m_ar [axicb_map_pkg::MST_NB],
    input logic [axicb_map_pkg::MST_NB-1:0]  i_m_arvalid,
    input logic [axicb_map_pkg::MST_NB-1:0]  o_m_arready,
    input axicb_bus_pkg::r_t                 o_m_r [axicb_map_pkg::MST_NB],
    input logic [axicb_map_pkg::MST_NB-1:0]  o_m_rvalid,
    input logic [axicb_map_pkg::MST_NB-1:0]  i_m_rready,
    input axicb_bus_pkg::ar_t                o_s_ar [axicb_map_pkg::SLV_NB],
    input logic [axicb_map_pkg::SLV_NB-1:0]  o_s_arvalid,
    input logic [axicb_map_pkg::SLV_NB-1:0]  i_s_arready,
    input axicb_bus_pkg::r_t                 i_s_r [axicb_map_pkg::SLV_NB],
    input logic [axicb_map_pkg::SLV_NB-1:0]  i_s_rvalid,
    input logic [axicb_map_pkg::SLV_NB-1:0]  o_s_rready,
    input logic [axicb_map_pkg::MST_NB-1:0]  arb_req [axicb_map_pkg::SLV_NB],
    input logic [axicb_map_pkg::MST_NB-1:0]  arb_grant [axicb_map_pkg::SLV_NB],
    input axicb_bus_pkg::ar_t                arb_ar [axicb_map_pkg::SLV_NB],
    input logic [axicb_map_pkg::SLV_NB-1:0]  arb_valid,
    input logic [axicb_map_pkg::SLV_NB-1:0]  ar_ready,
    input axicb_bus_pkg::r_t                 slv_r [axicb_map_pkg::SLV_NB],
    input logic [axicb_map_pkg::SLV_NB-1:0]  slv_rvalid,
    input logic [axicb_map_pkg::SLV_NB-1:0]  slv_rready
);

    localparam int TOP = axicb_map_pkg::ID_W - 1;

    int                               err_cnt = 0;
    logic                             seen_ar;
    int unsigned                      m_cnt;
    int unsigned                      s_cnt;
    logic [axicb_map_pkg::MST_NB-1:0] m_map_fire;
    logic [axicb_map_pkg::MST_NB-1:0] slv_to_m;
    axicb_bus_pkg::r_t                s_r_last [axicb_map_pkg::SLV_NB];

    function automatic logic in_slave(input int s, input logic [axicb_map_pkg::ADDR_W-1:0] a);
        logic [axicb_map_pkg::ADDR_W-1:0] base;
        logic [axicb_map_pkg::ADDR_W-1:0] last;
        base = (s == 0) ? axicb_map_pkg::SLV0_BASE : axicb_map_pkg::SLV1_BASE;
        last = (s == 0) ? axicb_map_pkg::SLV0_LAST : axicb_map_pkg::SLV1_LAST;
        return (a - base) <= (last - base);
    endfunction

    ////////////////////
    // Transfer counters
    ////////////////////

    for (genvar m = 0; m < axicb_map_pkg::MST_NB; m++) begin : MAP_FIRE_GEN
        assign m_map_fire[m] = i_m_arvalid[m] & o_m_arready[m] &
                               (in_slave(0, i_m_ar[m].addr) | in_slave(1, i_m_ar[m].addr));
    end

    // Masters with a slave response waiting at a slice output
    always_comb begin
        slv_to_m = '0;
        for (int s = 0; s < axicb_map_pkg::SLV_NB; s++) begin
            if (slv_rvalid[s]) begin
                slv_to_m[slv_r[s].id[TOP]] = 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        s_r_last <= i_s_r;
    end

    always_ff @(posedge aclk) begin
        if (i_reset) begin
            seen_ar <= 1'b0;
            m_cnt   <= 0;
            s_cnt   <= 0;
        end else begin
            seen_ar <= seen_ar | (|(i_m_arvalid & o_m_arready));
            m_cnt   <= m_cnt + $countones(m_map_fire);
            s_cnt   <= s_cnt + $countones(o_s_arvalid & i_s_arready);
        end
    end

    // Quiet until the first address is taken
    assert property (@(posedge aclk) disable iff (i_reset)
        !seen_ar |-> (o_s_arvalid == '0) && (o_m_rvalid == '0))
    else begin
        $error("A valid output went high before any address was accepted");
        err_cnt++;
    end

    // Empty AR slices mean every mapped address got through once
    assert property (@(posedge aclk) disable iff (i_reset)
        (o_s_arvalid == '0) |-> (s_cnt == m_cnt))
    else begin
        $error("Error s_cnt 0x%h expected 0x%h", s_cnt, m_cnt);
        err_cnt++;
    end

    ////////////////////
    // Slave side
    ////////////////////

    for (genvar s = 0; s < axicb_map_pkg::SLV_NB; s++) begin : SLV_CHK_GEN
        assert property (@(posedge aclk) disable iff (i_reset)
            o_s_arvalid[s] |-> in_slave(s, o_s_ar[s].addr))
        else begin
            $error("Error o_s_ar[%0d].addr 0x%h outside the slave range", s, o_s_ar[s].addr);
            err_cnt++;
        end

        assert property (@(posedge aclk) disable iff (i_reset)
            o_s_arvalid[s] && !i_s_arready[s] |=> o_s_arvalid[s] && $stable(o_s_ar[s]))
        else begin
            $error("Slave %0d address dropped or changed while stalled, now 0x%h", s, o_s_ar[s]);
            err_cnt++;
        end

        // Both requesting right after a grant, so the other master wins
        assert property (@(posedge aclk) disable iff (i_reset)
            arb_valid[s] && ar_ready[s] |=>
                (arb_req[s] != '1) || (arb_grant[s] != $past(arb_grant[s])))
        else begin
            $error("Error arb_grant[%0d] 0x%h repeated under contention", s, arb_grant[s]);
            err_cnt++;
        end

        // A free R slice shows the slave response on the next edge
        assert property (@(posedge aclk) disable iff (i_reset)
            i_s_rvalid[s] && o_s_rready[s] && (!slv_rvalid[s] || slv_rready[s]) |=>
                slv_rvalid[s] && (slv_r[s] == s_r_last[s]))
        else begin
            $error("Error slv_r[%0d] 0x%h expected 0x%h", s, slv_r[s], s_r_last[s]);
            err_cnt++;
        end

        assert property (@(posedge aclk) disable iff (i_reset)
            slv_rvalid[s] && slv_rready[s] |->
                o_m_rvalid[slv_r[s].id[TOP]] && (o_m_r[slv_r[s].id[TOP]] == slv_r[s]))
        else begin
            $error("Error o_m_r 0x%h expected 0x%h", o_m_r[slv_r[s].id[TOP]], slv_r[s]);
            err_cnt++;
        end

        for (genvar m = 0; m < axicb_map_pkg::MST_NB; m++) begin : ROUTE_GEN
            assert property (@(posedge aclk) disable iff (i_reset)
                arb_valid[s] && ar_ready[s] && arb_grant[s][m] |->
                    i_m_arvalid[m] && o_m_arready[m] && in_slave(s, i_m_ar[m].addr) &&
                    (arb_ar[s].addr == i_m_ar[m].addr) && (arb_ar[s].id[TOP] == 1'(m)) &&
                    (arb_ar[s].id[TOP-1:0] == i_m_ar[m].id[TOP-1:0]))
            else begin
                $error("Error arb_ar[%0d] 0x%h from master ar 0x%h", s, arb_ar[s], i_m_ar[m]);
                err_cnt++;
            end
        end
    end

    ////////////////////
    // Master side
    ////////////////////

    for (genvar m = 0; m < axicb_map_pkg::MST_NB; m++) begin : MST_CHK_GEN
        // A slave response for the same master goes first
        assert property (@(posedge aclk) disable iff (i_reset)
            i_m_arvalid[m] && o_m_arready[m] && !m_map_fire[m] |=>
                o_m_rvalid[m] && (slv_to_m[m] ? (o_m_r[m].resp != axicb_bus_pkg::RESP_DECERR) :
                                  ((o_m_r[m].resp == axicb_bus_pkg::RESP_DECERR) &&
                                   (o_m_r[m].id == $past(i_m_ar[m].id)))))
        else begin
            $error("Master %0d got no DECERR one cycle after an unmapped read", m);
            err_cnt++;
        end

        assert property (@(posedge aclk) disable iff (i_reset)
            o_m_rvalid[m] && (o_m_r[m].resp != axicb_bus_pkg::RESP_DECERR) |->
                (o_m_r[m].id[TOP] == 1'(m)))
        else begin
            $error("Error o_m_r[%0d].id 0x%h names another master", m, o_m_r[m].id);
            err_cnt++;
        end

        assert property (@(posedge aclk) disable iff (i_reset)
            o_m_rvalid[m] && !i_m_rready[m] |=> o_m_rvalid[m] && $stable(o_m_r[m]))
        else begin
            $error("Master %0d response dropped or changed while stalled, now 0x%h",
                   m, o_m_r[m]);
            err_cnt++;
        end
    end

endmodule

// ==== tests/axicb_tb.sv ====
////////////////////
// Masters stall rready at random, slaves stall arready and rvalid.
// Slave models answer with the zero-extended address and RESP_OKAY.
////////////////////

`timescale 1ns/10ps

module axicb_tb;

    localparam int MST_NB  = axicb_map_pkg::MST_NB;
    localparam int SLV_NB  = axicb_map_pkg::SLV_NB;
    localparam int N_READS = 300;
    localparam int TOTAL   = N_READS * MST_NB;

    logic               aclk;
    logic               i_reset;
    axicb_bus_pkg::ar_t m_ar [MST_NB];
    logic [MST_NB-1:0]  m_arvalid;
    logic [MST_NB-1:0]  m_arready;
    axicb_bus_pkg::r_t  m_r [MST_NB];
    logic [MST_NB-1:0]  m_rvalid;
    logic [MST_NB-1:0]  m_rready;
    axicb_bus_pkg::ar_t s_ar [SLV_NB];
    logic [SLV_NB-1:0]  s_arvalid;
    logic [SLV_NB-1:0]  s_arready;
    axicb_bus_pkg::r_t  s_r [SLV_NB];
    logic [SLV_NB-1:0]  s_rvalid;
    logic [SLV_NB-1:0]  s_rready;

    // Handshakes seen at the last rising edge
    logic [MST_NB-1:0]  m_ar_fire;
    logic [MST_NB-1:0]  m_r_fire;
    logic [SLV_NB-1:0]  s_ar_fire;
    logic [SLV_NB-1:0]  s_r_fire;
    axicb_bus_pkg::ar_t s_ar_seen [SLV_NB];

    axicb_bus_pkg::ar_t slv_q [SLV_NB][$];
    logic [31:0]        lfsr;
    int                 issued [MST_NB];
    int                 responses;

    bind axicb_read_xbar axicb_properties props0 (.*);

    axicb_read_xbar dut0 (
        .aclk        (aclk),
        .i_reset     (i_reset),
        .i_m_ar      (m_ar),
        .i_m_arvalid (m_arvalid),
        .o_m_arready (m_arready),
        .o_m_r       (m_r),
        .o_m_rvalid  (m_rvalid),
        .i_m_rready  (m_rready),
        .o_s_ar      (s_ar),
        .o_s_arvalid (s_arvalid),
        .i_s_arready (s_arready),
        .i_s_r       (s_r),
        .i_s_rvalid  (s_rvalid),
        .o_s_rready  (s_rready)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    always @(posedge aclk) begin
        m_ar_fire <= m_arvalid & m_arready;
        m_r_fire  <= m_rvalid & m_rready;
        s_ar_fire <= s_arvalid & s_arready;
        s_r_fire  <= s_rvalid & s_rready;
        s_ar_seen <= s_ar;
    end

    ////////////////////
    // Random source
    ////////////////////

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // Slave 0 gets half the reads, slave 1 and the hole a quarter each
    task automatic new_read(input int m);
        logic [15:0] sel;
        logic [15:0] low;
        logic [15:0] id;
        take_bits(2, sel);
        take_bits(12, low);
        take_bits(axicb_map_pkg::ID_W, id);
        case (sel[1:0])
            2'd1:    m_ar[m].addr = axicb_map_pkg::SLV1_BASE + {4'h0, low[11:0]};
            2'd3:    m_ar[m].addr = 16'hC000 + {4'h0, low[11:0]};
            default: m_ar[m].addr = axicb_map_pkg::SLV0_BASE + {4'h0, low[11:0]};
        endcase
        m_ar[m].id   = id[axicb_map_pkg::ID_W-1:0];
        m_arvalid[m] = 1'b1;
        issued[m]++;
    endtask

    task automatic drive_masters();
        logic [15:0] go;
        logic [15:0] stall;
        for (int m = 0; m < MST_NB; m++) begin
            if (m_ar_fire[m]) begin
                m_arvalid[m] = 1'b0;
            end
            if (m_r_fire[m]) begin
                responses++;
            end
            // Ready three cycles in four
            take_bits(2, stall);
            m_rready[m] = |stall[1:0];
            if (!m_arvalid[m] && issued[m] < N_READS) begin
                take_bits(1, go);
                if (go[0]) begin
                    new_read(m);
                end
            end
        end
    endtask

    task automatic drive_slaves();
        logic [15:0]        bits;
        axicb_bus_pkg::ar_t ar;
        for (int s = 0; s < SLV_NB; s++) begin
            if (s_ar_fire[s]) begin
                slv_q[s].push_back(s_ar_seen[s]);
            end
            if (s_r_fire[s]) begin
                s_rvalid[s] = 1'b0;
            end
            take_bits(2, bits);
            s_arready[s] = bits[0];
            if (!s_rvalid[s] && slv_q[s].size() > 0 && bits[1]) begin
                ar          = slv_q[s].pop_front();
                s_r[s].id   = ar.id;
                s_r[s].data = 32'(ar.addr);
                s_r[s].resp = axicb_bus_pkg::RESP_OKAY;
                s_rvalid[s] = 1'b1;
            end
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        lfsr      = 32'h31cf_84ab;
        i_reset   = 1'b1;
        m_arvalid = '0;
        m_rready  = '1;
        s_arready = '0;
        s_rvalid  = '0;
        responses = 0;
        for (int k = 0; k < MST_NB; k++) begin
            m_ar[k]   = '0;
            issued[k] = 0;
        end
        for (int k = 0; k < SLV_NB; k++) begin
            s_r[k] = '0;
        end
        repeat (3) @(posedge aclk);
        @(negedge aclk);
        i_reset = 1'b0;
        while (responses < TOTAL) begin
            @(negedge aclk);
            drive_masters();
            drive_slaves();
        end
        repeat (2) @(negedge aclk);
        $display("Reads %0d, responses %0d, assertion errors %0d",
                 TOTAL, responses, dut0.props0.err_cnt);
        if (dut0.props0.err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Run limit of 40 cycles per read
    initial begin
        repeat (TOTAL * 40) @(posedge aclk);
        $display("Watchdog expired with %0d of %0d responses received", responses, TOTAL);
        $display("Test FAILED");
        $finish;
    end

endmodule
